// File: eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

    // 24C16 style part, 2 KB behind an 11 bit address
    typedef logic [10:0] addr_t;
    typedef logic [7:0]  byte_t;
    typedef logic [1:0]  phase_t;   // scl quarter, 0 low .. 2 high
    typedef logic [3:0]  bitcnt_t;  // bits of one byte incl. ack slot

    localparam logic [3:0] DEVICE_CODE = 4'b1010;
    localparam logic       RW_WRITE    = 1'b0;
    localparam logic       RW_READ     = 1'b1;
    localparam logic       MASTER_NACK = 1'b1; // sda level after the last read byte

    localparam int BYTE_BITS          = 9;
    localparam int SCL_QUARTER_CYCLES = 4;  // 16 clk per scl bit
    localparam int QCNT_W             = $clog2(SCL_QUARTER_CYCLES);

    typedef logic [QCNT_W-1:0] qcnt_t;

    typedef enum logic [1:0]
    {
        BUS_START      = 2'd0,
        BUS_STOP       = 2'd1,
        BUS_WRITE_BYTE = 2'd2,
        BUS_READ_BYTE  = 2'd3
    } bus_cmd_t;

    typedef enum logic [3:0]
    {
        S_IDLE,
        S_START,
        S_CTRL_W,
        S_ADDR,
        S_DATA_W,
        S_RESTART,
        S_CTRL_R,
        S_DATA_R,
        S_STOP,
        S_DONE
    } seq_state_t;

endpackage

`default_nettype wire

// File: scl_timer.sv
`timescale 1ns/1ns
`default_nettype none

module scl_timer
(
    input  wire                 CLK,
    input  wire                 RESET,
    input  wire                 run,
    output logic                tick,
    output eeprom_pkg::phase_t  phase
);

    eeprom_pkg::qcnt_t cyc_cnt;     // clk cycles inside the current quarter
    logic              cyc_wrap;

    assign cyc_wrap = (cyc_cnt == eeprom_pkg::qcnt_t'(eeprom_pkg::SCL_QUARTER_CYCLES - 1));

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            cyc_cnt <= '0;
            tick    <= 1'b0;
            phase   <= '0;
        end
        else if (!run)
        begin
            // parked between commands, next run starts in quarter 0
            cyc_cnt <= '0;
            tick    <= 1'b0;
            phase   <= '0;
        end
        else
        begin
            tick <= cyc_wrap;
            if (cyc_wrap)
            begin
                cyc_cnt <= '0;
                phase   <= phase + 2'd1;   // quarter being entered
            end
            else
            begin
                cyc_cnt <= cyc_cnt + 1'b1;
            end
        end
    end

    // engine acts on phase only together with tick
    phase_moves_on_tick: assert property (
        @(posedge CLK) disable iff (RESET)
        !$stable(phase) |-> tick
    );

endmodule

`default_nettype wire

// File: i2c_bit_engine.sv
`timescale 1ns/1ns
`default_nettype none

module i2c_bit_engine
(
    input  wire                   CLK,
    input  wire                   RESET,
    input  eeprom_pkg::bus_cmd_t  cmd,
    input  wire                   cmd_valid,
    input  eeprom_pkg::byte_t     tx_byte,
    input  wire                   tick,
    input  eeprom_pkg::phase_t    phase,
    output logic                  run,
    output logic                  busy,
    output logic                  done,
    output logic                  slave_ack,
    output eeprom_pkg::byte_t     rx_byte,
    output logic                  scl,
    output logic                  sda_low,
    input  wire                   sda_in
);

    eeprom_pkg::bus_cmd_t cmd_r;
    logic [8:0]           shift_r;    // sda levels out, sampled bits shift in at bit 0
    eeprom_pkg::bitcnt_t  bit_cnt;
    logic                 sda_smp;
    logic                 frame_cmd;
    logic                 last_tick;
    logic                 take_cmd;

    assign take_cmd  = cmd_valid && !busy;
    assign frame_cmd = (cmd_r == eeprom_pkg::BUS_START) || (cmd_r == eeprom_pkg::BUS_STOP);
    assign last_tick = busy && tick && (phase == 2'd0) &&
                       (frame_cmd ||
                        bit_cnt == eeprom_pkg::bitcnt_t'(eeprom_pkg::BYTE_BITS - 1));

    assign run = busy;   // timer runs for the whole command

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy    <= 1'b0;
            done    <= 1'b0;
            scl     <= 1'b1;
            sda_low <= 1'b0;
            bit_cnt <= '0;
        end
        else
        begin
            done <= last_tick;
            if (take_cmd)
            begin
                busy    <= 1'b1;
                bit_cnt <= '0;
                case (cmd)
                    eeprom_pkg::BUS_STOP:       sda_low <= 1'b1;  // scl is low here
                    eeprom_pkg::BUS_WRITE_BYTE: sda_low <= ~tx_byte[7];
                    default:                    sda_low <= 1'b0;
                endcase
            end
            else if (busy && tick)
            begin
                case (phase)
                    2'd1: scl <= 1'b1;
                    2'd2:
                    begin
                        // sda edge while scl high
                        if (cmd_r == eeprom_pkg::BUS_START)
                            sda_low <= 1'b1;
                        else if (cmd_r == eeprom_pkg::BUS_STOP)
                            sda_low <= 1'b0;
                    end
                    2'd3:
                    begin
                        if (cmd_r != eeprom_pkg::BUS_STOP)
                            scl <= 1'b0;   // bus stays idle high after stop
                    end
                    default:
                    begin
                        if (last_tick)
                        begin
                            busy <= 1'b0;
                        end
                        else
                        begin
                            bit_cnt <= bit_cnt + 1'b1;
                            sda_low <= ~shift_r[7];  // next msb
                        end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (take_cmd)
        begin
            cmd_r <= cmd;
            if (cmd == eeprom_pkg::BUS_READ_BYTE)
                shift_r <= {8'hff, tx_byte[0]};   // release sda, then master ack
            else
                shift_r <= {tx_byte, 1'b1};       // ninth bit released for slave ack
        end
        else if (busy && tick)
        begin
            if (phase == 2'd2)
                sda_smp <= sda_in;
            if (phase == 2'd0)
            begin
                shift_r <= {shift_r[7:0], sda_smp};
                if (last_tick && !frame_cmd)
                begin
                    rx_byte   <= shift_r[7:0];
                    slave_ack <= ~sda_smp;        // low on the ack bit
                end
            end
        end
    end

    // sequencer must wait for the previous command to finish
    no_cmd_while_busy: assert property (
        @(posedge CLK) disable iff (RESET)
        cmd_valid |-> !busy
    );

endmodule

`default_nettype wire

// File: eeprom_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module eeprom_sequencer
(
    input  wire                   CLK,
    input  wire                   RESET,
    input  wire                   wr,
    input  wire                   rd,
    input  eeprom_pkg::addr_t     addr,
    input  eeprom_pkg::byte_t     wdata,
    output eeprom_pkg::bus_cmd_t  cmd,
    output logic                  cmd_valid,
    output eeprom_pkg::byte_t     tx_byte,
    input  wire                   busy,
    input  wire                   done,
    input  wire                   slave_ack,
    input  eeprom_pkg::byte_t     rx_byte,
    output eeprom_pkg::byte_t     rdata,
    output logic                  ack,
    output logic                  nack
);

    eeprom_pkg::seq_state_t state;
    eeprom_pkg::seq_state_t state_next;
    eeprom_pkg::bus_cmd_t   cmd_next;
    eeprom_pkg::byte_t      tx_next;
    eeprom_pkg::addr_t      addr_r;
    eeprom_pkg::byte_t      wdata_r;
    logic                   is_read;
    logic                   req_take;
    logic                   sent_byte;
    logic                   issue;

    assign req_take  = (state == eeprom_pkg::S_IDLE) && (wr || rd) && !busy;
    assign sent_byte = (state == eeprom_pkg::S_CTRL_W) || (state == eeprom_pkg::S_ADDR) ||
                       (state == eeprom_pkg::S_DATA_W) || (state == eeprom_pkg::S_CTRL_R);

    always_comb
    begin
        state_next = state;
        case (state)
            eeprom_pkg::S_IDLE:
                if (req_take) state_next = eeprom_pkg::S_START;
            eeprom_pkg::S_START:
                if (done) state_next = eeprom_pkg::S_CTRL_W;
            eeprom_pkg::S_CTRL_W:
                if (done) state_next = slave_ack ? eeprom_pkg::S_ADDR : eeprom_pkg::S_STOP;
            eeprom_pkg::S_ADDR:
            begin
                if (done && !slave_ack)
                    state_next = eeprom_pkg::S_STOP;
                else if (done)
                    state_next = is_read ? eeprom_pkg::S_RESTART : eeprom_pkg::S_DATA_W;
            end
            eeprom_pkg::S_DATA_W:
                if (done) state_next = eeprom_pkg::S_STOP;
            eeprom_pkg::S_RESTART:
                if (done) state_next = eeprom_pkg::S_CTRL_R;
            eeprom_pkg::S_CTRL_R:
                if (done) state_next = slave_ack ? eeprom_pkg::S_DATA_R : eeprom_pkg::S_STOP;
            eeprom_pkg::S_DATA_R:
                if (done) state_next = eeprom_pkg::S_STOP;
            eeprom_pkg::S_STOP:
                if (done) state_next = eeprom_pkg::S_DONE;
            default:
                state_next = eeprom_pkg::S_IDLE;
        endcase
    end

    // each bus state starts its command on entry
    assign issue = (state_next != state) &&
                   (state_next != eeprom_pkg::S_IDLE) && (state_next != eeprom_pkg::S_DONE);

    always_comb
    begin
        cmd_next = eeprom_pkg::BUS_WRITE_BYTE;
        tx_next  = '0;
        case (state_next)
            eeprom_pkg::S_START,
            eeprom_pkg::S_RESTART: cmd_next = eeprom_pkg::BUS_START;
            eeprom_pkg::S_STOP:    cmd_next = eeprom_pkg::BUS_STOP;
            eeprom_pkg::S_CTRL_W:
                tx_next = {eeprom_pkg::DEVICE_CODE, addr_r[10:8], eeprom_pkg::RW_WRITE};
            eeprom_pkg::S_ADDR:    tx_next = addr_r[7:0];
            eeprom_pkg::S_DATA_W:  tx_next = wdata_r;
            eeprom_pkg::S_CTRL_R:
                tx_next = {eeprom_pkg::DEVICE_CODE, addr_r[10:8], eeprom_pkg::RW_READ};
            eeprom_pkg::S_DATA_R:
            begin
                cmd_next = eeprom_pkg::BUS_READ_BYTE;
                tx_next  = {7'd0, eeprom_pkg::MASTER_NACK};  // single byte read
            end
            default:               tx_next = '0;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= eeprom_pkg::S_IDLE;
            cmd_valid <= 1'b0;
            ack       <= 1'b0;
            nack      <= 1'b0;
            is_read   <= 1'b0;
        end
        else
        begin
            state     <= state_next;
            cmd_valid <= issue;
            ack       <= (state == eeprom_pkg::S_STOP) && done;
            if (req_take)
            begin
                is_read <= !wr;    // write wins when both are raised
                nack    <= 1'b0;
            end
            else if (done && sent_byte && !slave_ack)
            begin
                nack <= 1'b1;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (req_take)
        begin
            addr_r  <= addr;
            wdata_r <= wdata;
        end
        if (issue)
        begin
            cmd     <= cmd_next;
            tx_byte <= tx_next;
        end
        if (done && state == eeprom_pkg::S_DATA_R)
            rdata <= rx_byte;
    end

    ack_single_cycle: assert property (
        @(posedge CLK) disable iff (RESET)
        ack |=> !ack
    );

endmodule

`default_nettype wire

// File: eeprom_master_top.sv
`timescale 1ns/1ns
`default_nettype none

module eeprom_master_top
(
    input  wire                 CLK,
    input  wire                 RESET,
    input  wire                 wr,
    input  wire                 rd,
    input  eeprom_pkg::addr_t   addr,
    input  eeprom_pkg::byte_t   wdata,
    output eeprom_pkg::byte_t   rdata,
    output logic                ack,
    output logic                nack,
    output logic                scl,
    inout  wire                 sda
);

    eeprom_pkg::bus_cmd_t cmd;
    eeprom_pkg::byte_t    tx_byte;
    eeprom_pkg::byte_t    rx_byte;
    eeprom_pkg::phase_t   phase;
    logic                 cmd_valid;
    logic                 busy;
    logic                 done;
    logic                 slave_ack;
    logic                 run;
    logic                 tick;
    logic                 sda_low;
    logic                 sda_in;

    // open drain, pull-up sits outside
    assign sda    = sda_low ? 1'b0 : 1'bz;
    assign sda_in = sda;

    scl_timer scl_timer_inst
    (
        .CLK    (CLK),
        .RESET  (RESET),
        .run    (run),
        .tick   (tick),
        .phase  (phase)
    );

    i2c_bit_engine i2c_bit_engine_inst
    (
        .CLK        (CLK),
        .RESET      (RESET),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .tx_byte    (tx_byte),
        .tick       (tick),
        .phase      (phase),
        .run        (run),
        .busy       (busy),
        .done       (done),
        .slave_ack  (slave_ack),
        .rx_byte    (rx_byte),
        .scl        (scl),
        .sda_low    (sda_low),
        .sda_in     (sda_in)
    );

    eeprom_sequencer eeprom_sequencer_inst
    (
        .CLK        (CLK),
        .RESET      (RESET),
        .wr         (wr),
        .rd         (rd),
        .addr       (addr),
        .wdata      (wdata),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .tx_byte    (tx_byte),
        .busy       (busy),
        .done       (done),
        .slave_ack  (slave_ack),
        .rx_byte    (rx_byte),
        .rdata      (rdata),
        .ack        (ack),
        .nack       (nack)
    );

endmodule

`default_nettype wire

// File: tb_eeprom_model.sv
`timescale 1ns/1ns
`default_nettype none

module tb_eeprom_model
(
    input  wire        scl,
    inout  wire        sda,
    input  wire [3:0]  withhold_ack,   // one bit per byte index since the last stop
    output int         violations
);

    logic [7:0]  mem [0:2047];
    logic        drive_low;
    logic        in_frame;
    logic        seen_low;
    logic        expect_ctrl;
    logic        addr_stage;
    logic        data_stage;
    logic        addr_valid;
    logic        send_next;
    logic        sending;
    logic [2:0]  page;
    logic [10:0] ptr;
    logic [7:0]  shreg;
    logic [7:0]  out_byte;
    int          bit_idx;
    int          byte_idx;

    assign sda = drive_low ? 1'b0 : 1'bz;

    initial
    begin
        for (int a = 0; a < 2048; a++)
            mem[a] = 8'(a[7:0] ^ (a >> 3));   // fill from every address bit
        drive_low  = 1'b0;
        in_frame   = 1'b0;
        seen_low   = 1'b0;
        addr_valid = 1'b0;
        sending    = 1'b0;
        send_next  = 1'b0;
        bit_idx    = 0;
        byte_idx   = 0;
        violations = 0;
    end

    // start or repeated start
    always @(negedge sda)
    begin
        if (scl === 1'b1)
        begin
            in_frame    = 1'b1;
            expect_ctrl = 1'b1;
            addr_stage  = 1'b0;
            data_stage  = 1'b0;
            sending     = 1'b0;
            send_next   = 1'b0;
            bit_idx     = 0;
        end
    end

    always @(posedge sda)
    begin
        if (scl === 1'b1)
        begin
            in_frame   = 1'b0;
            addr_valid = 1'b0;
            byte_idx   = 0;
            bit_idx    = 0;
        end
    end

    always @(posedge scl)
    begin
        if (!in_frame && seen_low)
            violations++;   // clocking outside start/stop
        if (bit_idx < 8 && !sending)
            shreg = {shreg[6:0], sda === 1'b0 ? 1'b0 : 1'b1};
        bit_idx++;
    end

    always @(negedge scl)
    begin
        seen_low = 1'b1;
        if (bit_idx == 8 && sending)
        begin
            drive_low = 1'b0;   // master drives its ack
        end
        else if (bit_idx == 8)
        begin
            decode_byte();
        end
        else if (bit_idx == 9)
        begin
            bit_idx   = 0;
            byte_idx++;
            sending   = send_next;
            send_next = 1'b0;
            drive_low = sending ? !out_byte[7] : 1'b0;
        end
        else if (sending && bit_idx > 0 && bit_idx < 8)
        begin
            drive_low = !out_byte[7 - bit_idx];
        end
    end

    task automatic decode_byte();
        logic give_ack;
        give_ack = !(byte_idx < 4 && withhold_ack[byte_idx]);
        if (expect_ctrl && shreg[7:4] != eeprom_pkg::DEVICE_CODE)
        begin
            violations++;
            give_ack = 1'b0;
        end
        else if (expect_ctrl && shreg[0] && !addr_valid)
        begin
            violations++;   // read with no address set
            give_ack = 1'b0;
        end
        else if (!expect_ctrl && !addr_stage && !data_stage)
        begin
            violations++;
            give_ack = 1'b0;
        end
        if (give_ack)
        begin
            if (expect_ctrl)
            begin
                page        = shreg[3:1];
                expect_ctrl = 1'b0;
                addr_stage  = !shreg[0];
                if (shreg[0])
                begin
                    send_next = 1'b1;
                    out_byte  = mem[ptr];
                end
            end
            else if (addr_stage)
            begin
                ptr        = {page, shreg};
                addr_valid = 1'b1;
                addr_stage = 1'b0;
                data_stage = 1'b1;
            end
            else
            begin
                mem[ptr]   = shreg;
                data_stage = 1'b0;
            end
        end
        drive_low = give_ack;
    endtask

endmodule

`default_nettype wire

// File: tb_eeprom_master.sv
`timescale 1ns/1ns
`default_nettype none

module tb_eeprom_master;

    localparam int  NUM_TXN  = 50;
    localparam longint LIMIT_NS = longint'(NUM_TXN) * 39 * 4 *
                                  eeprom_pkg::SCL_QUARTER_CYCLES * 20 * 2;

    logic                CLK;
    logic                RESET;
    logic                wr;
    logic                rd;
    eeprom_pkg::addr_t   addr;
    eeprom_pkg::byte_t   wdata;
    eeprom_pkg::byte_t   rdata;
    logic                ack;
    logic                nack;
    logic                scl;
    wire                 sda;
    logic [3:0]          withhold_ack;
    int                  violations;
    int                  errors;
    int                  accepted;
    int                  ack_seen;
    logic [15:0]         lfsr_state;
    eeprom_pkg::byte_t   shadow [0:2047];

    pullup (sda);

    eeprom_master_top eeprom_master_top_inst
    (
        .CLK    (CLK),
        .RESET  (RESET),
        .wr     (wr),
        .rd     (rd),
        .addr   (addr),
        .wdata  (wdata),
        .rdata  (rdata),
        .ack    (ack),
        .nack   (nack),
        .scl    (scl),
        .sda    (sda)
    );

    tb_eeprom_model tb_eeprom_model_inst
    (
        .scl          (scl),
        .sda          (sda),
        .withhold_ack (withhold_ack),
        .violations   (violations)
    );

    always #10 CLK = ~CLK;

    always @(negedge CLK)
    begin
        if (!RESET && ack)
            ack_seen++;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v          = {v[14:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // expected read byte, shadow follows acked writes only
    function automatic eeprom_pkg::byte_t expected_read(input eeprom_pkg::addr_t a);
        return shadow[a];
    endfunction

    task automatic check(input string name, input logic [15:0] exp, input logic [15:0] act);
        if (exp !== act)
        begin
            errors++;
            $display("ERROR %0t ns %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic run_txn(input logic w, input logic r, input eeprom_pkg::addr_t a,
                           input eeprom_pkg::byte_t d, input int noise_after,
                           output eeprom_pkg::byte_t got, output logic got_nack);
        @(posedge CLK);
        wr    <= w;
        rd    <= r;
        addr  <= a;
        wdata <= d;
        @(posedge CLK);
        wr <= 1'b0;
        rd <= 1'b0;
        if (noise_after > 0)
        begin
            repeat (noise_after) @(posedge CLK);
            wr    <= 1'b1;   // must be dropped
            addr  <= ~a;
            wdata <= ~d;
            @(posedge CLK);
            wr <= 1'b0;
        end
        @(negedge CLK);
        while (!ack)
            @(negedge CLK);
        got      = rdata;
        got_nack = nack;
        accepted++;
        if (w && !got_nack)
            shadow[a] = d;
    endtask

    task automatic read_and_compare(input eeprom_pkg::addr_t a);
        eeprom_pkg::byte_t got;
        logic              got_nack;
        run_txn(1'b0, 1'b1, a, 8'h00, 0, got, got_nack);
        check("nack", 16'(1'b0), 16'(got_nack));
        check("rdata", 16'(expected_read(a)), 16'(got));
    endtask

    initial
    begin
        #(LIMIT_NS);
        $display("watchdog expired, transactions did not finish in time");
        $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        eeprom_pkg::byte_t got;
        logic              got_nack;
        logic [15:0]       v;
        eeprom_pkg::addr_t a;
        CLK          = 1'b0;
        RESET        = 1'b1;
        wr           = 1'b0;
        rd           = 1'b0;
        addr         = '0;
        wdata        = '0;
        withhold_ack = 4'b0000;
        errors       = 0;
        accepted     = 0;
        ack_seen     = 0;
        lfsr_state   = 16'd19754;
        for (int i = 0; i < 2048; i++)
            shadow[i] = 8'(i[7:0] ^ (i >> 3));
        repeat (3) @(posedge CLK);
        RESET <= 1'b0;
        repeat (4) @(negedge CLK);
        check("scl", 16'(1'b1), 16'(scl));
        check("sda", 16'(1'b1), 16'(sda));
        check("ack", 16'(1'b0), 16'(ack));
        check("nack", 16'(1'b0), 16'(nack));

        run_txn(1'b1, 1'b0, 11'h5a3, 8'hc6, 0, got, got_nack);
        check("nack", 16'(1'b0), 16'(got_nack));
        read_and_compare(11'h5a3);

        for (int i = 0; i < 20; i++)
        begin
            take_bits(11, v);
            a = v[10:0];
            take_bits(8, v);
            run_txn(1'b1, 1'b0, a, v[7:0], 0, got, got_nack);
            check("nack", 16'(1'b0), 16'(got_nack));
            take_bits(1, v);
            if (v[0])
            begin
                take_bits(11, v);
                a = v[10:0];
            end
            read_and_compare(a);
        end

        // wr and rd together act as a write
        run_txn(1'b1, 1'b1, 11'h0f1, 8'h3c, 0, got, got_nack);
        read_and_compare(11'h0f1);
        // request raised mid transfer is dropped
        run_txn(1'b1, 1'b0, 11'h712, 8'h99, 40, got, got_nack);
        read_and_compare(11'h712);
        read_and_compare(~11'h712);

        withhold_ack = 4'b0010;   // address byte
        run_txn(1'b1, 1'b0, 11'h2e7, 8'h11, 0, got, got_nack);
        check("nack", 16'(1'b1), 16'(got_nack));
        withhold_ack = 4'b0000;
        read_and_compare(11'h2e7);

        repeat (4) @(negedge CLK);
        check("ack_count", 16'(accepted), 16'(ack_seen));
        $display("errors %0d, protocol violations %0d", errors, violations);
        if (errors == 0 && violations == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
eeprom_pkg.sv
scl_timer.sv
i2c_bit_engine.sv
eeprom_sequencer.sv
eeprom_master_top.sv
tb_eeprom_model.sv
tb_eeprom_master.sv

// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove build output and log"

test:
	verilator --binary --timing -j 0 --top-module tb_eeprom_master -f verilog.f -o sim_eeprom
	./obj_dir/sim_eeprom | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
